/* vec_in_pkg.sv */
`default_nettype none

package vec_in_pkg;

    localparam int ADDR_W   = 10;                 // vector memory address width
    localparam int DATA_W   = 10;                 // element width
    localparam int OP_COUNT = 7;                  // width of one-hot op field

    localparam int CMD_WRITE_BIT = 0;             // write flag inside command word
    localparam int CMD_SEL_BIT   = OP_COUNT;      // bram select, 0 = a, 1 = b

    typedef logic [DATA_W-1:0] word_t;            // one vector element
    typedef logic [ADDR_W-1:0] addr_t;            // one memory address

    // opcode field carried in bits 2:0 of a command byte
    typedef enum logic [2:0] {
        OP_WRITE   = 3'd0,                        // load a vector from the link
        OP_READ    = 3'd1,
        OP_SUM     = 3'd2,
        OP_AVG     = 3'd3,
        OP_EUC     = 3'd4,                        // euclidean distance
        OP_MAN     = 3'd5,                        // manhattan distance
        OP_DOT     = 3'd6,                        // dot product
        OP_INVALID = 3'd7                         // never accepted
    } opcode_e;

    // {bram sel, dot, man, euc, avg, sum, read, write}
    typedef logic [OP_COUNT:0] command_t;

    // a received byte, seen as a command or as element data
    typedef union packed {
        struct packed {
            logic       bram_sel;                 // target memory
            logic [3:0] unused;                   // ignored by the decoder
            opcode_e    opcode;
        } cmd;
        logic [7:0] data;                         // raw payload byte
    } rx_byte_u;

endpackage

`default_nettype wire

/* command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module command_decoder import vec_in_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     byte_accept,                 // byte taken from the link this cycle
    input  rx_byte_u rx_byte,
    input  logic     write_done,                  // completion of a write
    input  logic     op_done,                     // completion of any other op
    output command_t command                      // held command word
);

    logic                cmd_idle;                // no command in progress
    logic                cmd_complete;            // completion matching active op
    logic [OP_COUNT-1:0] op_onehot;               // decoded opcode of incoming byte
    logic                op_valid;                // opcode is one of the seven

    assign cmd_idle = (command[OP_COUNT-1:0] == '0); // select bit alone never held

    // write finishes on write_done, every other op on op_done
    assign cmd_complete = command[CMD_WRITE_BIT] ? write_done : op_done;

    assign op_valid = (op_onehot != '0);

    always_comb begin
        op_onehot = '0;
        case (rx_byte.cmd.opcode)
            OP_WRITE:   op_onehot[0] = 1'b1;
            OP_READ:    op_onehot[1] = 1'b1;
            OP_SUM:     op_onehot[2] = 1'b1;
            OP_AVG:     op_onehot[3] = 1'b1;
            OP_EUC:     op_onehot[4] = 1'b1;
            OP_MAN:     op_onehot[5] = 1'b1;
            OP_DOT:     op_onehot[6] = 1'b1;
            OP_INVALID: op_onehot    = '0;        // dropped, command stays empty
            default:    op_onehot    = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            command <= '0;
        end else if (cmd_idle) begin
            // bytes only count as commands while nothing is active
            if (byte_accept && op_valid) begin
                command <= {rx_byte.cmd.bram_sel, op_onehot};
            end
        end else if (cmd_complete) begin
            command <= '0;                        // back to idle, ready for next byte
        end
    end

endmodule

`default_nettype wire

/* write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module write_ctrl import vec_in_pkg::*; #(
    parameter int num_elements = 1024             // elements per vector write
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     byte_accept,                 // byte taken from the link
    input  rx_byte_u rx_byte,
    input  logic     write_en,                    // write bit of the held command
    input  logic     bram_sel,                    // 0 = memory a, 1 = memory b
    output logic     wea_a,                       // one-cycle write strobe, memory a
    output logic     wea_b,                       // one-cycle write strobe, memory b
    output addr_t    write_addr,                  // element index, doubles as counter
    output word_t    write_data,                  // assembled element
    output logic     write_done                   // pulse after the final write
);

    localparam addr_t last_addr = addr_t'(num_elements - 1);

    logic       hi_phase;                         // next data byte is the high byte
    logic       last_seen;                        // final element already taken
    logic [7:0] low_byte;                         // held low byte of current element
    logic       data_accept;                      // byte belongs to the write stream
    logic       low_accept;
    logic       high_accept;                      // element complete this cycle
    logic       mem_write;                        // a memory write happens this cycle

    // stream closes after the last element until the command drops
    assign data_accept = byte_accept && write_en && !last_seen;
    assign low_accept  = data_accept && !hi_phase;
    assign high_accept = data_accept && hi_phase;
    assign mem_write   = wea_a || wea_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_phase   <= 1'b0;
            last_seen  <= 1'b0;
            wea_a      <= 1'b0;
            wea_b      <= 1'b0;
            write_addr <= '0;
            write_done <= 1'b0;
        end else begin
            wea_a <= high_accept && !bram_sel;    // strobe lasts one cycle
            wea_b <= high_accept && bram_sel;

            // done one cycle after the final element is stored
            write_done <= mem_write && last_seen;

            // address moves on once the current element is written
            if (mem_write) begin
                write_addr <= last_seen ? '0 : write_addr + 1'b1;
            end

            if (!write_en) begin
                hi_phase  <= 1'b0;                // idle, realign to a low byte
                last_seen <= 1'b0;
            end else if (data_accept) begin
                hi_phase <= !hi_phase;
                if (hi_phase && (write_addr == last_addr)) begin
                    last_seen <= 1'b1;            // high byte of element n-1
                end
            end
        end
    end

    // element payload, bits 9:8 come from the high byte
    always_ff @(posedge clk) begin
        if (low_accept) begin
            low_byte <= rx_byte.data;
        end
        if (high_accept) begin
            write_data <= {rx_byte.data[DATA_W-9:0], low_byte};
        end
    end

endmodule

`default_nettype wire

/* vec_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_bram import vec_in_pkg::*; (
    input  logic  clk,
    input  logic  wea,                            // port a write strobe
    input  addr_t addra,                          // port a write address
    input  word_t dina,                           // port a write data
    input  addr_t addrb,                          // port b read address
    output word_t doutb                           // port b data, one cycle late
);

    word_t mem [2**ADDR_W];                       // one full vector

    // port a, write only
    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dina;
        end
    end

    // port b, registered read
    always_ff @(posedge clk) begin
        doutb <= mem[addrb];
    end

endmodule

`default_nettype wire

/* input_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module input_interface import vec_in_pkg::*; #(
    parameter int num_elements = 1024             // elements per vector
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_valid,                  // byte offered by the link
    output logic       rx_ready,                  // always ready once out of reset
    input  logic [7:0] rx_data,
    input  logic       op_done,                   // completion from main controller
    input  addr_t      bram_a_read_addr,
    input  addr_t      bram_b_read_addr,
    output command_t   command,                   // held command for main controller
    output word_t      bram_a_dout,
    output word_t      bram_b_dout
);

    logic     byte_accept;                        // handshake completes this cycle
    rx_byte_u rx_byte;                            // incoming byte, both views
    logic     write_done;
    logic     wea_a;
    logic     wea_b;
    addr_t    write_addr;
    word_t    write_data;

    assign byte_accept = rx_valid && rx_ready;
    assign rx_byte     = rx_data;

    // no back-pressure source, only reset holds the link off
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= 1'b1;
        end
    end

    command_decoder u_command_decoder (
        .clk         (clk),
        .rst         (rst),
        .byte_accept (byte_accept),
        .rx_byte     (rx_byte),
        .write_done  (write_done),                // write completes itself
        .op_done     (op_done),
        .command     (command)
    );

    write_ctrl #(
        .num_elements (num_elements)
    ) u_write_ctrl (
        .clk         (clk),
        .rst         (rst),
        .byte_accept (byte_accept),
        .rx_byte     (rx_byte),
        .write_en    (command[CMD_WRITE_BIT]),    // active write decided by decoder
        .bram_sel    (command[CMD_SEL_BIT]),
        .wea_a       (wea_a),
        .wea_b       (wea_b),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .write_done  (write_done)
    );

    // both memories share the write bus, strobes pick the target
    vec_bram bram_a (
        .clk   (clk),
        .wea   (wea_a),
        .addra (write_addr),
        .dina  (write_data),
        .addrb (bram_a_read_addr),
        .doutb (bram_a_dout)
    );

    vec_bram bram_b (
        .clk   (clk),
        .wea   (wea_b),
        .addra (write_addr),
        .dina  (write_data),
        .addrb (bram_b_read_addr),
        .doutb (bram_b_dout)
    );

endmodule

`default_nettype wire

/* tb_input_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_input_interface import vec_in_pkg::*; ();

    localparam int n_elem      = 16;               // elements per vector in this run
    localparam int op_bytes    = 3;                // junk bytes sent during a non-write op
    localparam int mix_rounds  = 4;                // write plus non-write pairs in test 6
    localparam int write_bytes = 1 + 2 * n_elem;   // command byte and element bytes
    localparam int total_bytes = 2 * write_bytes + 6 * (1 + op_bytes) + 1 + write_bytes
                                 + mix_rounds * (write_bytes + 1 + op_bytes);
    localparam int total_reads = 5 * n_elem;       // five sweeps
    localparam int max_cycles  = 4 * (total_bytes + total_reads) + 500;

    logic       clk;
    logic       rst;
    logic       rx_valid;
    logic       rx_ready;
    logic [7:0] rx_data;
    logic       op_done;
    addr_t      bram_a_read_addr;
    addr_t      bram_b_read_addr;
    command_t   command;
    word_t      bram_a_dout;
    word_t      bram_b_dout;

    word_t      mem_a [n_elem];                    // expected contents of memory a
    word_t      mem_b [n_elem];                    // expected contents of memory b
    command_t   model_cmd;                         // expected command word
    int         model_count;                       // elements taken by the current write
    logic       model_hi;                          // next data byte is a high byte
    logic [7:0] model_low;                         // held low byte

    int error_count;
    int check_count;
    int test_errors_at_start;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    input_interface #(
        .num_elements (n_elem)
    ) uut (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .rx_ready         (rx_ready),
        .rx_data          (rx_data),
        .op_done          (op_done),
        .bram_a_read_addr (bram_a_read_addr),
        .bram_b_read_addr (bram_b_read_addr),
        .command          (command),
        .bram_a_dout      (bram_a_dout),
        .bram_b_dout      (bram_b_dout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                    // 40 ns period
    end

    // hard stop in case a wait never ends
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #2;                                        // inputs move just after the edge
    endtask

    task automatic check_command(input string name, input command_t expected,
                                 input command_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: command expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: word expected %h, actual %h", name, expected, actual);
        end
    endtask

    // reference behaviour for one accepted byte
    task automatic update_model(input logic [7:0] b);
        if (model_cmd[6:0] == 7'd0) begin
            if (b[2:0] != 3'd7) begin              // opcode 7 is dropped
                model_cmd   = {b[7], 7'(1 << b[2:0])};
                model_count = 0;
                model_hi    = 1'b0;
            end
        end else if (model_cmd[0] && (model_count < n_elem)) begin
            if (!model_hi) begin
                model_low = b;
            end else begin
                if (model_cmd[7]) begin
                    mem_b[model_count] = {b[1:0], model_low};
                end else begin
                    mem_a[model_count] = {b[1:0], model_low};
                end
                model_count++;
            end
            model_hi = !model_hi;
        end
        // bytes during a non-write op are dropped
    endtask

    task automatic send_byte(input logic [7:0] b);
        int   gap;
        logic taken;
        gap = $urandom_range(0, 3);
        repeat (gap) step();                       // random idle gap on the link
        rx_valid = 1'b1;
        rx_data  = b;
        taken    = 1'b0;
        while (!taken) begin
            taken = rx_ready;                      // ready only moves on edges
            step();
        end
        rx_valid = 1'b0;
        rx_data  = 8'($urandom);
        update_model(b);
    endtask

    task automatic pulse_op_done();
        op_done = 1'b1;
        step();
        op_done = 1'b0;
        if ((model_cmd[6:0] != 7'd0) && !model_cmd[0]) begin
            model_cmd = '0;                        // only non-write ops finish this way
        end
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        check_command(name, model_cmd, command);   // write still held after the last byte
        while (command != '0) begin
            step();
            waited++;
        end
        if (waited != 2) begin
            error_count++;
            $display("%s: command cleared %0d cycles after the last byte, not 2", name, waited);
        end
        model_cmd = '0;
    endtask

    task automatic read_sweep(input string name, input bit use_a, input bit use_b);
        int i;
        for (i = 0; i < n_elem; i++) begin
            bram_a_read_addr = addr_t'(i);
            bram_b_read_addr = addr_t'(i);
            step();                                // one cycle read latency
            if (use_a) begin
                check_word($sformatf("%s a[%0d]", name, i), mem_a[i], bram_a_dout);
            end
            if (use_b) begin
                check_word($sformatf("%s b[%0d]", name, i), mem_b[i], bram_b_dout);
            end
        end
    endtask

    task automatic run_write(input string name, input logic sel, input bit mid_op_done);
        int i;
        send_byte({sel, 4'($urandom), 3'd0});
        check_command(name, model_cmd, command);
        for (i = 0; i < 2 * n_elem; i++) begin
            if (mid_op_done && (i == n_elem)) begin
                pulse_op_done();                   // must not end the write
                check_command(name, model_cmd, command);
            end
            send_byte(8'($urandom));
        end
        wait_idle(name);
    endtask

    task automatic run_op(input string name, input logic sel, input logic [2:0] op);
        int i;
        send_byte({sel, 4'($urandom), op});
        check_command(name, {sel, 7'(1 << op)}, command);
        for (i = 0; i < op_bytes; i++) begin
            send_byte(8'($urandom));
        end
        check_command(name, model_cmd, command);   // junk bytes leave it alone
        pulse_op_done();
        check_command(name, '0, command);
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name,
                     error_count - test_errors_at_start);
        end
        test_errors_at_start = error_count;
    endtask

    initial begin : stimulus
        int         k;
        logic [2:0] op;
        void'($urandom(32'hd582));
        rst              = 1'b1;
        rx_valid         = 1'b0;
        rx_data          = 8'h00;
        op_done          = 1'b0;
        bram_a_read_addr = '0;
        bram_b_read_addr = '0;
        model_cmd        = '0;
        model_count      = 0;
        model_hi         = 1'b0;
        model_low        = 8'h00;
        error_count      = 0;
        check_count      = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        test_errors_at_start = 0;

        repeat (10) step();                        // reset for 10 cycles
        rst = 1'b0;
        step();

        check_command("reset", '0, command);
        if (rx_ready !== 1'b1) begin
            error_count++;
            $display("reset: rx_ready is not high after reset");
        end
        finish_test("reset");

        run_write("write_a", 1'b0, 1'b0);
        read_sweep("write_a", 1'b1, 1'b0);
        finish_test("write_a");

        run_write("write_b", 1'b1, 1'b0);
        read_sweep("write_b", 1'b1, 1'b1);         // a must be untouched
        finish_test("write_b");

        for (k = 1; k <= 6; k++) begin
            run_op("ops", 1'($urandom), 3'(k));
        end
        read_sweep("ops", 1'b1, 1'b1);
        finish_test("ops");

        send_byte({1'($urandom), 4'($urandom), 3'd7});
        step();
        check_command("ignored", '0, command);
        pulse_op_done();                           // idle, nothing to finish
        check_command("ignored", '0, command);
        run_write("ignored", 1'($urandom), 1'b1);
        read_sweep("ignored", 1'b1, 1'b1);
        finish_test("ignored");

        for (k = 0; k < mix_rounds; k++) begin
            run_write("mixed", 1'($urandom), 1'b0);
            op = 3'($urandom_range(1, 6));
            run_op("mixed", 1'($urandom), op);
        end
        read_sweep("mixed", 1'b1, 1'b1);
        finish_test("mixed");

        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
vec_in_pkg.sv
command_decoder.sv
write_ctrl.sv
vec_bram.sv
input_interface.sv
tb_input_interface.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, then search the log for the fail message
verilator --binary --timing --top-module tb_input_interface -f src.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
